// File: all.f
source/channel_pkg.sv
source/slot_control.sv
source/slot_state_mem.sv
source/carrier_mixer.sv
source/ca_code_gen.sv
source/correlator.sv
source/channel_top.sv
tests/channel_tb.sv

// File: tests/channel_stim.txt
# I prn carrier_inc expected_slot | S sample
# E tag i_early q_early i_prompt q_prompt i_late q_late
I 1 64 0
I 2 32 1
S 3
S -2
S 1
S -4
S 2
S 3
S -1
S -3
E 0 -1 0 -5 12 7 6
E 1 -2 1 0 -1 0 5
S 1
S 2
S -2
S 3
S -3
S -1
S 2
S 1
E 0 -2 -1 0 5 4 5
E 1 3 -4 1 -4 -1 -8

// File: tests/channel_tb.sv
`timescale 1ns/1ns
`default_nettype none

module channel_tb
   import channel_pkg::*;
();

   localparam int CLK_PERIOD     = 20;
   localparam int RESET_CYCLES   = 4;
   localparam int TIMEOUT_CYCLES = 40;
   localparam int RESULT_LATENCY = 4;
   localparam int SEED           = 52490;

   logic                          clk;
   logic                          reset_i;
   logic                          data_valid_i;
   logic signed [INPUT_WIDTH-1:0] data_i;
   logic                          init_i;
   logic [PRN_WIDTH-1:0]          prn_i;
   logic [PHASE_WIDTH-1:0]        carrier_inc_i;
   logic                          init_ready_o;
   logic [SLOT_WIDTH-1:0]         init_slot_o;
   logic                          acc_valid_o;
   logic [SLOT_WIDTH-1:0]         acc_tag_o;
   acc_set_t                      acc_o;

   // Rising edges seen by the stimulus process, and the edge that took the last sample.
   int edge_cnt;
   int sample_edge;
   int results_seen;
   int slots_taken;

   channel_top channel_top_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .data_valid_i  (data_valid_i),
      .data_i        (data_i),
      .init_i        (init_i),
      .prn_i         (prn_i),
      .carrier_inc_i (carrier_inc_i),
      .init_ready_o  (init_ready_o),
      .init_slot_o   (init_slot_o),
      .acc_valid_o   (acc_valid_o),
      .acc_tag_o     (acc_tag_o),
      .acc_o         (acc_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////
   // Compare tasks.
   ////////////////////////////////////////////////////////////

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at the first error.");
   endtask

   function automatic string acc_text(input acc_set_t a);
      return $sformatf("(%0d %0d %0d %0d %0d %0d)", a.i_early, a.q_early,
                       a.i_prompt, a.q_prompt, a.i_late, a.q_late);
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("error at %0t ns: %s expected %b, got %b",
                                  $time, name, exp, got));
      end
   endtask

   task automatic check_slot(input string name, input logic [SLOT_WIDTH-1:0] got,
                             input logic [SLOT_WIDTH-1:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("error at %0t ns: %s expected %0d, got %0d",
                                  $time, name, exp, got));
      end
   endtask

   task automatic check_acc(input string name, input acc_set_t got, input acc_set_t exp);
      if (got !== exp) begin
         report_failure($sformatf("error at %0t ns: %s expected %s, got %s",
                                  $time, name, acc_text(exp), acc_text(got)));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus tasks.
   ////////////////////////////////////////////////////////////

   task automatic tick();
      @(posedge clk);
      edge_cnt++;
   endtask

   // Idle cycles with no result due.
   task automatic wait_gap(input int gap);
      int waited;
      waited = 0;
      while (edge_cnt + 2 - sample_edge < gap) begin
         tick();
         @(negedge clk);
         check_bit("acc_valid_o", acc_valid_o, 1'b0);
         // No free slot is left once every slot has been taken.
         if (slots_taken == NUM_SLOTS) begin
            check_bit("init_ready_o", init_ready_o, 1'b0);
         end
         waited++;
         if (waited > TIMEOUT_CYCLES) begin
            report_failure("Timed out while waiting out the gap between samples.");
         end
      end
   endtask

   task automatic drive_sample(input int value);
      int gap;
      gap = SAMPLE_GAP_MIN + int'($urandom % 4);
      wait_gap(gap);
      tick();
      data_valid_i <= 1'b1;
      data_i       <= INPUT_WIDTH'(value);
      tick();
      data_valid_i <= 1'b0;
      sample_edge = edge_cnt;
      @(negedge clk);
      check_bit("init_ready_o", init_ready_o, 1'b0);
   endtask

   task automatic run_init(input int prn, input int inc, input int slot);
      int waited;
      waited = 0;
      while (init_ready_o !== 1'b1) begin
         tick();
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT_CYCLES) begin
            report_failure("Timed out waiting for init_ready_o.");
         end
      end
      tick();
      init_i        <= 1'b1;
      prn_i         <= PRN_WIDTH'(prn);
      carrier_inc_i <= PHASE_WIDTH'(inc);
      @(negedge clk);
      check_bit("init_ready_o", init_ready_o, 1'b1);
      check_slot("init_slot_o", init_slot_o, SLOT_WIDTH'(slot));
      tick();
      init_i <= 1'b0;
      slots_taken++;
      @(negedge clk);
      // All slots taken.
      if (slot == NUM_SLOTS - 1) begin
         check_bit("init_ready_o", init_ready_o, 1'b0);
      end
   endtask

   // Result for slot s is due RESULT_LATENCY + s edges after the sample edge.
   task automatic wait_result(input int tag, input acc_set_t exp);
      int   waited;
      logic expect_valid;
      bit   seen;
      waited = 0;
      seen   = 1'b0;
      while (!seen) begin
         tick();
         @(negedge clk);
         expect_valid = (edge_cnt - sample_edge == RESULT_LATENCY + tag);
         check_bit("acc_valid_o", acc_valid_o, expect_valid);
         check_bit("init_ready_o", init_ready_o, 1'b0);
         seen = (acc_valid_o === 1'b1);
         waited++;
         if (waited > TIMEOUT_CYCLES) begin
            report_failure("Timed out waiting for acc_valid_o.");
         end
      end
      check_slot("acc_tag_o", acc_tag_o, SLOT_WIDTH'(tag));
      check_acc("acc_o", acc_o, exp);
      results_seen++;
   endtask

   task automatic skip_line(input int fd);
      int c;
      c = $fgetc(fd);
      while (c != 10 && c != -1) begin
         c = $fgetc(fd);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////////////////////////

   initial begin
      int         fd;
      int         n;
      logic [7:0] kind;
      int         prn;
      int         inc;
      int         slot;
      int         value;
      int         tag;
      int         sums [6];
      acc_set_t   exp;
      bit         done;

      reset_i       = 1'b1;
      data_valid_i  = 1'b0;
      data_i        = '0;
      init_i        = 1'b0;
      prn_i         = '0;
      carrier_inc_i = '0;
      edge_cnt      = 0;
      sample_edge   = -100;
      results_seen  = 0;
      slots_taken   = 0;
      void'($urandom(SEED));

      fd = $fopen("tests/channel_stim.txt", "r");
      if (fd == 0) begin
         report_failure("Could not open tests/channel_stim.txt.");
      end

      repeat (RESET_CYCLES) begin
         tick();
      end
      reset_i <= 1'b0;
      @(negedge clk);
      check_bit("acc_valid_o", acc_valid_o, 1'b0);
      check_bit("init_ready_o", init_ready_o, 1'b1);

      done = 1'b0;
      while (!done) begin
         n = $fscanf(fd, " %c", kind);
         if (n != 1) begin
            done = 1'b1;
         end else begin
            case (kind)
               "#": skip_line(fd);
               "I": begin
                  n = $fscanf(fd, "%d %d %d", prn, inc, slot);
                  if (n != 3) begin
                     report_failure("Malformed init line in the stimulus file.");
                  end
                  run_init(prn, inc, slot);
               end
               "S": begin
                  n = $fscanf(fd, "%d", value);
                  if (n != 1) begin
                     report_failure("Malformed sample line in the stimulus file.");
                  end
                  drive_sample(value);
               end
               "E": begin
                  n = $fscanf(fd, "%d %d %d %d %d %d %d", tag, sums[0], sums[1],
                              sums[2], sums[3], sums[4], sums[5]);
                  if (n != 7) begin
                     report_failure("Malformed result line in the stimulus file.");
                  end
                  exp.i_early  = ACC_WIDTH'(sums[0]);
                  exp.q_early  = ACC_WIDTH'(sums[1]);
                  exp.i_prompt = ACC_WIDTH'(sums[2]);
                  exp.q_prompt = ACC_WIDTH'(sums[3]);
                  exp.i_late   = ACC_WIDTH'(sums[4]);
                  exp.q_late   = ACC_WIDTH'(sums[5]);
                  wait_result(tag, exp);
               end
               default: report_failure("Unknown line kind in the stimulus file.");
            endcase
         end
      end
      $fclose(fd);

      // A few quiet cycles in which no stray result may appear.
      wait_gap(3 * SAMPLE_GAP_MIN);

      if (results_seen == 0) begin
         report_failure("The stimulus file held no result lines.");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: source/channel_top.sv
`timescale 1ns/1ns
`default_nettype none

module channel_top
   import channel_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset_i,
   input  logic                          data_valid_i,
   input  logic signed [INPUT_WIDTH-1:0] data_i,
   input  logic                          init_i,
   input  logic [PRN_WIDTH-1:0]          prn_i,
   input  logic [PHASE_WIDTH-1:0]        carrier_inc_i,
   output logic                          init_ready_o,
   output logic [SLOT_WIDTH-1:0]         init_slot_o,
   output logic                          acc_valid_o,
   output logic [SLOT_WIDTH-1:0]         acc_tag_o,
   output acc_set_t                      acc_o
);

   logic                          init_wr;
   logic signed [INPUT_WIDTH-1:0] data_q;
   pipe_ctl_t                     s0_ctl;
   pipe_ctl_t                     s1_ctl;
   pipe_ctl_t                     s2_ctl;
   slot_state_t                   state_q;
   slot_state_t                   code_state;
   slot_state_t                   state_d;
   logic [PHASE_WIDTH-1:0]        phase_next;
   mix_t                          mix;
   code_bits_t                    code;

   // Sample is held for the whole sweep over the slots.
   always_ff @(posedge clk) begin
      if (data_valid_i) begin
         data_q <= data_i;
      end
   end

   // Next state takes the phase from the mixer and the rest from the code generator.
   always_comb begin
      state_d       = code_state;
      state_d.phase = phase_next;
   end

   slot_control slot_control_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .data_valid_i  (data_valid_i),
      .init_i        (init_i),
      .prn_i         (prn_i),
      .carrier_inc_i (carrier_inc_i),
      .init_ready_o  (init_ready_o),
      .init_slot_o   (init_slot_o),
      .init_wr_o     (init_wr),
      .s0_ctl_o      (s0_ctl)
   );

   slot_state_mem slot_state_mem_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .init_wr_i   (init_wr),
      .init_slot_i (init_slot_o),
      .s0_ctl_i    (s0_ctl),
      .wr_ctl_i    (s1_ctl),
      .state_d_i   (state_d),
      .state_q_o   (state_q),
      .s1_ctl_o    (s1_ctl)
   );

   carrier_mixer carrier_mixer_i (
      .clk      (clk),
      .reset_i  (reset_i),
      .s1_ctl_i (s1_ctl),
      .data_i   (data_q),
      .phase_i  (state_q.phase),
      .phase_o  (phase_next),
      .mix_o    (mix)
   );

   ca_code_gen ca_code_gen_i (
      .clk      (clk),
      .reset_i  (reset_i),
      .s1_ctl_i (s1_ctl),
      .state_i  (state_q),
      .state_o  (code_state),
      .code_o   (code),
      .s2_ctl_o (s2_ctl)
   );

   correlator correlator_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .s2_ctl_i    (s2_ctl),
      .mix_i       (mix),
      .code_i      (code),
      .acc_valid_o (acc_valid_o),
      .acc_tag_o   (acc_tag_o),
      .acc_o       (acc_o)
   );

endmodule

`default_nettype wire

// File: source/correlator.sv
`timescale 1ns/1ns
`default_nettype none

module correlator
   import channel_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_i,
   input  pipe_ctl_t             s2_ctl_i,
   input  mix_t                  mix_i,
   input  code_bits_t            code_i,
   output logic                  acc_valid_o,
   output logic [SLOT_WIDTH-1:0] acc_tag_o,
   output acc_set_t              acc_o
);

   acc_set_t acc_mem [NUM_SLOTS];
   acc_set_t base;
   acc_set_t sum;

   // Code wipe-off, a chip of one flips the sign.
   function automatic logic signed [ACC_WIDTH-1:0] acc_step(
      input logic signed [ACC_WIDTH-1:0] acc,
      input logic signed [MIX_WIDTH-1:0] value,
      input logic                        chip);
      return chip ? acc - value : acc + value;
   endfunction

   always_comb begin
      base         = s2_ctl_i.first ? '0 : acc_mem[s2_ctl_i.slot];
      sum.i_early  = acc_step(base.i_early,  mix_i.i, code_i.early);
      sum.q_early  = acc_step(base.q_early,  mix_i.q, code_i.early);
      sum.i_prompt = acc_step(base.i_prompt, mix_i.i, code_i.prompt);
      sum.q_prompt = acc_step(base.q_prompt, mix_i.q, code_i.prompt);
      sum.i_late   = acc_step(base.i_late,   mix_i.i, code_i.late);
      sum.q_late   = acc_step(base.q_late,   mix_i.q, code_i.late);
   end

   always_ff @(posedge clk) begin
      if (s2_ctl_i.valid) begin
         acc_mem[s2_ctl_i.slot] <= sum;
         acc_o                  <= sum;
         acc_tag_o              <= s2_ctl_i.slot;
      end
   end

   // Result pulse at the end of each period.
   always_ff @(posedge clk) begin
      if (reset_i) begin
         acc_valid_o <= 1'b0;
      end else begin
         acc_valid_o <= s2_ctl_i.valid && s2_ctl_i.last;
      end
   end

endmodule

`default_nettype wire

// File: source/ca_code_gen.sv
`timescale 1ns/1ns
`default_nettype none

module ca_code_gen
   import channel_pkg::*;
(
   input  logic        clk,
   input  logic        reset_i,
   input  pipe_ctl_t   s1_ctl_i,
   input  slot_state_t state_i,
   output slot_state_t state_o,
   output code_bits_t  code_o,
   output pipe_ctl_t   s2_ctl_o
);

   logic [2*TAP_WIDTH-1:0] taps;
   logic [LFSR_WIDTH:1]    g1_next;
   logic [LFSR_WIDTH:1]    g2_next;
   code_bits_t             code_d;

   // Shift towards stage 10, feedback enters stage 1.
   function automatic logic [LFSR_WIDTH:1] lfsr_step(input logic [LFSR_WIDTH:1] g,
                                                     input logic [LFSR_WIDTH:1] mask);
      return {g[LFSR_WIDTH-1:1], ^(g & mask)};
   endfunction

   function automatic logic ca_chip(input logic [LFSR_WIDTH:1] g1,
                                    input logic [LFSR_WIDTH:1] g2,
                                    input logic [2*TAP_WIDTH-1:0] tap_pair);
      return g1[LFSR_WIDTH] ^ g2[tap_pair[2*TAP_WIDTH-1 -: TAP_WIDTH]]
             ^ g2[tap_pair[TAP_WIDTH-1:0]];
   endfunction

   always_comb begin
      taps          = G2_TAPS[s1_ctl_i.prn];
      g1_next       = lfsr_step(state_i.g1, G1_FB_MASK);
      g2_next       = lfsr_step(state_i.g2, G2_FB_MASK);
      code_d.prompt = ca_chip(state_i.g1, state_i.g2, taps);
      code_d.early  = ca_chip(g1_next, g2_next, taps);
      code_d.late   = state_i.late_chip;
      // Phase is filled in by the carrier side.
      state_o           = state_i;
      state_o.g1        = g1_next;
      state_o.g2        = g2_next;
      state_o.late_chip = code_d.prompt;
   end

   always_ff @(posedge clk) begin
      code_o <= code_d;
      if (reset_i) begin
         s2_ctl_o <= '0;
      end else begin
         s2_ctl_o <= s1_ctl_i;
      end
   end

   // PRN comes from init, the tap table covers 1 to PRN_MAX only.
   a_prn_range: assert property (@(posedge clk) disable iff (reset_i)
      s1_ctl_i.valid |-> (s1_ctl_i.prn >= 1 && s1_ctl_i.prn <= PRN_MAX));

endmodule

`default_nettype wire

// File: source/carrier_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module carrier_mixer
   import channel_pkg::*;
(
   input  logic                          clk,
   input  logic                          reset_i,
   input  pipe_ctl_t                     s1_ctl_i,
   input  logic signed [INPUT_WIDTH-1:0] data_i,
   input  logic [PHASE_WIDTH-1:0]        phase_i,
   output logic [PHASE_WIDTH-1:0]        phase_o,
   output mix_t                          mix_o
);

   logic [1:0]        index;
   logic signed [1:0] cos_v;
   logic signed [1:0] sin_v;
   mix_t              mix_d;

   // Lookup uses the phase before the step.
   assign index   = phase_i[PHASE_WIDTH-1 -: 2];
   assign phase_o = phase_i + s1_ctl_i.carrier_inc;

   always_comb begin
      case (index)
         2'd0:    begin cos_v = 2'sd1;  sin_v = 2'sd0;  end
         2'd1:    begin cos_v = 2'sd0;  sin_v = 2'sd1;  end
         2'd2:    begin cos_v = -2'sd1; sin_v = 2'sd0;  end
         default: begin cos_v = 2'sd0;  sin_v = -2'sd1; end
      endcase
      mix_d.i = data_i * cos_v;
      mix_d.q = data_i * sin_v;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         mix_o <= '0;
      end else begin
         mix_o <= mix_d;
      end
   end

endmodule

`default_nettype wire

// File: source/slot_state_mem.sv
`timescale 1ns/1ns
`default_nettype none

module slot_state_mem
   import channel_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset_i,
   input  logic                  init_wr_i,
   input  logic [SLOT_WIDTH-1:0] init_slot_i,
   input  pipe_ctl_t             s0_ctl_i,
   input  pipe_ctl_t             wr_ctl_i,
   input  slot_state_t           state_d_i,
   output slot_state_t           state_q_o,
   output pipe_ctl_t             s1_ctl_o
);

   slot_state_t state_mem [NUM_SLOTS];

   // Init write takes the slot over from any write-back.
   always_ff @(posedge clk) begin
      if (init_wr_i) begin
         state_mem[init_slot_i] <= SLOT_STATE_INIT;
      end else if (wr_ctl_i.valid) begin
         state_mem[wr_ctl_i.slot] <= state_d_i;
      end
   end

   // Registered read.
   always_ff @(posedge clk) begin
      state_q_o <= state_mem[s0_ctl_i.slot];
      if (reset_i) begin
         s1_ctl_o <= '0;
      end else begin
         s1_ctl_o <= s0_ctl_i;
      end
   end

   // Init is only accepted with an empty pipeline.
   a_no_init_collision: assert property (@(posedge clk) disable iff (reset_i)
      !(init_wr_i && wr_ctl_i.valid));

endmodule

`default_nettype wire

// File: source/slot_control.sv
`timescale 1ns/1ns
`default_nettype none

module slot_control
   import channel_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic                   data_valid_i,
   input  logic                   init_i,
   input  logic [PRN_WIDTH-1:0]   prn_i,
   input  logic [PHASE_WIDTH-1:0] carrier_inc_i,
   output logic                   init_ready_o,
   output logic [SLOT_WIDTH-1:0]  init_slot_o,
   output logic                   init_wr_o,
   output pipe_ctl_t              s0_ctl_o
);

   logic [NUM_SLOTS-1:0]   active_q;
   logic [PRN_WIDTH-1:0]   prn_q [NUM_SLOTS];
   logic [PHASE_WIDTH-1:0] inc_q [NUM_SLOTS];
   logic [CNT_WIDTH-1:0]   cnt_q [NUM_SLOTS];
   logic                   sweep_q;
   logic [SLOT_WIDTH-1:0]  sweep_slot_q;
   logic [PIPE_STAGES-1:0] inflight_q;
   logic                   issue;
   logic                   busy;

   ////////////////////////////////////////////////////////////
   // Slot allocation.
   ////////////////////////////////////////////////////////////

   // Lowest free slot wins.
   always_comb begin
      init_slot_o = '0;
      for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
         if (!active_q[s]) begin
            init_slot_o = SLOT_WIDTH'(s);
         end
      end
   end

   // Busy until the last item of a sample leaves the correlator.
   assign busy         = sweep_q || s0_ctl_o.valid || (|inflight_q);
   assign init_ready_o = !(&active_q) && !busy;
   assign init_wr_o    = init_i && init_ready_o;

   assign issue = sweep_q && active_q[sweep_slot_q];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         active_q <= '0;
      end else if (init_wr_o) begin
         active_q[init_slot_o] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (init_wr_o) begin
         prn_q[init_slot_o] <= prn_i;
         inc_q[init_slot_o] <= carrier_inc_i;
         cnt_q[init_slot_o] <= '0;
      end else if (issue) begin
         cnt_q[sweep_slot_q] <= cnt_q[sweep_slot_q] + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Slot sweep, one slot per cycle after each sample.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset_i) begin
         sweep_q      <= 1'b0;
         sweep_slot_q <= '0;
         inflight_q   <= '0;
         s0_ctl_o     <= '0;
      end else begin
         if (data_valid_i) begin
            sweep_q      <= 1'b1;
            sweep_slot_q <= '0;
         end else if (sweep_q) begin
            sweep_slot_q <= sweep_slot_q + 1'b1;
            sweep_q      <= (sweep_slot_q != SLOT_WIDTH'(NUM_SLOTS - 1));
         end
         inflight_q           <= {inflight_q[PIPE_STAGES-2:0], s0_ctl_o.valid};
         s0_ctl_o.valid       <= issue;
         s0_ctl_o.slot        <= sweep_slot_q;
         s0_ctl_o.prn         <= prn_q[sweep_slot_q];
         s0_ctl_o.carrier_inc <= inc_q[sweep_slot_q];
         s0_ctl_o.first       <= (cnt_q[sweep_slot_q] == '0);
         s0_ctl_o.last        <= (cnt_q[sweep_slot_q] == CNT_WIDTH'(ACC_LEN - 1));
      end
   end

   // The sweep must finish before the next sample arrives.
   a_sample_gap: assert property (@(posedge clk) disable iff (reset_i)
      data_valid_i |=> !data_valid_i [*SAMPLE_GAP_MIN-1]);

endmodule

`default_nettype wire

// File: source/channel_pkg.sv
`default_nettype none

package channel_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and constants.
   ////////////////////////////////////////////////////////////

   localparam int NUM_SLOTS      = 2;
   localparam int SLOT_WIDTH     = 1;
   localparam int PRN_WIDTH      = 4;
   localparam int PRN_MAX        = 8;
   localparam int INPUT_WIDTH    = 3;
   localparam int PHASE_WIDTH    = 8;
   localparam int MIX_WIDTH      = 4;
   localparam int ACC_WIDTH      = 12;
   localparam int ACC_LEN        = 8;
   localparam int CNT_WIDTH      = $clog2(ACC_LEN);
   localparam int SAMPLE_GAP_MIN = 4;
   localparam int PIPE_STAGES    = 3;
   localparam int LFSR_WIDTH     = 10;
   localparam int TAP_WIDTH      = 4;

   // Feedback masks, bit n of the mask is register stage n.
   localparam logic [LFSR_WIDTH:1] G1_FB_MASK = 10'b1000000100;
   localparam logic [LFSR_WIDTH:1] G2_FB_MASK = 10'b1110100110;

   // G2 output tap pairs for PRN 1 to 8, one nibble per tap.
   localparam logic [PRN_MAX:1][2*TAP_WIDTH-1:0] G2_TAPS = {
      8'h29, 8'h18, 8'h2A, 8'h19, 8'h59, 8'h48, 8'h37, 8'h26
   };

   ////////////////////////////////////////////////////////////
   // Shared types.
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [LFSR_WIDTH:1]    g1;
      logic [LFSR_WIDTH:1]    g2;
      logic [PHASE_WIDTH-1:0] phase;
      logic                   late_chip;
   } slot_state_t;

   localparam slot_state_t SLOT_STATE_INIT = '{
      g1: '1, g2: '1, phase: '0, late_chip: 1'b0
   };

   typedef struct packed {
      logic                   valid;
      logic [SLOT_WIDTH-1:0]  slot;
      logic [PRN_WIDTH-1:0]   prn;
      logic [PHASE_WIDTH-1:0] carrier_inc;
      logic                   first;
      logic                   last;
   } pipe_ctl_t;

   typedef struct packed {
      logic signed [MIX_WIDTH-1:0] i;
      logic signed [MIX_WIDTH-1:0] q;
   } mix_t;

   typedef struct packed {
      logic early;
      logic prompt;
      logic late;
   } code_bits_t;

   typedef struct packed {
      logic signed [ACC_WIDTH-1:0] i_early;
      logic signed [ACC_WIDTH-1:0] q_early;
      logic signed [ACC_WIDTH-1:0] i_prompt;
      logic signed [ACC_WIDTH-1:0] q_prompt;
      logic signed [ACC_WIDTH-1:0] i_late;
      logic signed [ACC_WIDTH-1:0] q_late;
   } acc_set_t;

endpackage

`default_nettype wire
